/* verilog/pit_defines.svh */
`ifndef PIT_DEFINES_SVH
`define PIT_DEFINES_SVH

// ============================================================
// timer geometry
// ============================================================

// number of timer channels
`define PIT_NUM_CH 3

// bus word and counter width
`define PIT_DATA_W 32

// 4-bit digits per counter, digits * 4 equals data width
`define PIT_DIGITS 8

// byte address, bits 5:4 pick the channel, bits 3:2 the register
`define PIT_ADR_W 6

`endif

/* verilog/pit_reg_pkg.sv */
`include "pit_defines.svh"

package pit_reg_pkg;

	// register index, address bits 3:2
	typedef enum logic [1:0] {
		COUNT  = 2'd0,
		MAXCNT = 2'd1,
		ONTIME = 2'd2,
		CTRL   = 2'd3
	} pit_reg_e;

	// one channel's lane of the control register
	typedef struct packed {
		logic pad;
		logic up;
		logic bcd;
		logic gate_en;
		logic ext_clk;
		logic auto_rld;
		logic en;
		logic load;
	} pit_ctrl_byte_s;

	// bus word, raw value or four control lanes (lane 3 unused)
	typedef union packed {
		logic [`PIT_DATA_W-1:0] raw;
		pit_ctrl_byte_s [3:0] lanes;
	} pit_word_u;

	// slave bus request as seen by the register block
	typedef struct packed {
		logic cs;
		logic cyc;
		logic stb;
		logic we;
		logic [`PIT_DATA_W/8-1:0] sel;
		logic [`PIT_ADR_W-1:0] adr;
		logic [`PIT_DATA_W-1:0] dat;
	} pit_bus_req_s;

endpackage

/* verilog/pit_cnt_pkg.sv */
`include "pit_defines.svh"

package pit_cnt_pkg;

	// per channel configuration, static bits plus the load pulse
	typedef struct packed {
		logic en;
		logic auto_rld;
		logic ext_clk;
		logic gate_en;
		logic bcd;
		logic up;
		// one cycle wide, set by a control write
		logic load;
	} pit_ch_cfg_s;

	// per channel limits
	typedef struct packed {
		logic [`PIT_DATA_W-1:0] maxcnt;
		logic [`PIT_DATA_W-1:0] ontime;
	} pit_ch_lim_s;

endpackage

/* verilog/pit_digit_counter.sv */
`timescale 1ns/1ps
`include "pit_defines.svh"

module pit_digit_counter #(
	parameter int NUM_DIGITS = `PIT_DIGITS
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic step_i,
	input  logic load_i,
	input  logic up_i,
	input  logic bcd_i,
	input  logic [NUM_DIGITS*4-1:0] load_val_i,
	output logic [NUM_DIGITS*4-1:0] count_o
);

	logic [NUM_DIGITS-1:0][3:0] dig_q;
	logic [NUM_DIGITS-1:0][3:0] dig_d;
	// digit sits at its wrap value for the current direction
	logic [NUM_DIGITS-1:0] at_wrap;
	// digit is allowed to advance this cycle
	logic [NUM_DIGITS-1:0] carry;
	logic [3:0] top_dig;

	// largest digit value, 9 in bcd and F in binary
	assign top_dig = bcd_i ? 4'd9 : 4'hf;

	always_comb begin
		for (int d = 0; d < NUM_DIGITS; d++) begin
			at_wrap[d] = up_i ? (dig_q[d] == top_dig) : (dig_q[d] == 4'd0);
			// ripple enable through the digit chain
			if (d == 0)
				carry[d] = step_i;
			else
				carry[d] = carry[d-1] & at_wrap[d-1];

			if (!carry[d])
				dig_d[d] = dig_q[d];
			else if (at_wrap[d])
				dig_d[d] = up_i ? 4'd0 : top_dig;
			else if (up_i)
				dig_d[d] = dig_q[d] + 4'd1;
			else
				dig_d[d] = dig_q[d] - 4'd1;
		end
	end

	// load beats step
	always_ff @(posedge clk_i) begin
		if (rst_i)
			dig_q <= '0;
		else if (load_i)
			dig_q <= load_val_i;
		else
			dig_q <= dig_d;
	end

	assign count_o = dig_q;

endmodule

/* verilog/pit_channel.sv */
`timescale 1ns/1ps
`include "pit_defines.svh"

module pit_channel (
	input  logic clk_i,
	input  logic rst_i,
	input  pit_cnt_pkg::pit_ch_cfg_s cfg_i,
	input  pit_cnt_pkg::pit_ch_lim_s lim_i,
	input  logic ext_clk_i,
	input  logic gate_i,
	output logic [`PIT_DATA_W-1:0] count_o,
	output logic stop_o,
	output logic out_o
);

	// [0] is the sampled input, [1] the sample before it
	logic [1:0] ext_q;
	logic ext_rise;
	logic cnt_en;
	logic at_ontime;
	logic at_tc;
	logic reload;
	logic ctr_load;
	logic ctr_step;
	logic [`PIT_DATA_W-1:0] reload_val;

	// ============================================================
	// count enable
	// ============================================================

	// external count input sampled in the clk_i domain
	always_ff @(posedge clk_i) begin
		if (rst_i)
			ext_q <= 2'b00;
		else
			ext_q <= {ext_q[0], ext_clk_i};
	end

	// one cycle pulse per rising edge
	assign ext_rise = ext_q[0] & ~ext_q[1];

	assign cnt_en = cfg_i.en
		& (cfg_i.ext_clk ? ext_rise : 1'b1)
		& (cfg_i.gate_en ? gate_i : 1'b1);

	// ============================================================
	// compare and terminal count
	// ============================================================
	assign at_ontime = count_o == lim_i.ontime;
	// terminal is maxcnt going up, zero going down
	assign at_tc = cfg_i.up ? (count_o == lim_i.maxcnt) : (count_o == '0);

	// the load pulse freezes everything else
	assign reload = ~cfg_i.load & cnt_en & at_tc & cfg_i.auto_rld;
	assign ctr_load = cfg_i.load | reload;
	// one-shot still takes the step past terminal count
	assign ctr_step = ~cfg_i.load & cnt_en & ~reload;
	assign stop_o = ~cfg_i.load & cnt_en & at_tc & ~cfg_i.auto_rld;

	// up counters restart from zero, down counters from the maximum
	assign reload_val = cfg_i.up ? '0 : lim_i.maxcnt;

	pit_digit_counter #(
		.NUM_DIGITS(`PIT_DIGITS)
	) i_ctr (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.step_i(ctr_step),
		.load_i(ctr_load),
		.up_i(cfg_i.up),
		.bcd_i(cfg_i.bcd),
		.load_val_i(reload_val),
		.count_o(count_o)
	);

	// ============================================================
	// output pin
	// ============================================================

	// active level is the inverse of up, terminal count overrides on-time
	always_ff @(posedge clk_i) begin
		if (rst_i)
			out_o <= 1'b0;
		else if (!cfg_i.load && cnt_en) begin
			if (at_tc)
				out_o <= cfg_i.up;
			else if (at_ontime)
				out_o <= ~cfg_i.up;
		end
	end

endmodule

/* verilog/pit_regs.sv */
`timescale 1ns/1ps
`include "pit_defines.svh"

module pit_regs (
	input  logic clk_i,
	input  logic rst_i,
	input  pit_reg_pkg::pit_bus_req_s req_i,
	output logic ack_o,
	output logic [`PIT_DATA_W-1:0] dat_o,
	input  logic [`PIT_NUM_CH-1:0][`PIT_DATA_W-1:0] count_i,
	input  logic [`PIT_NUM_CH-1:0] stop_i,
	output pit_cnt_pkg::pit_ch_cfg_s [`PIT_NUM_CH-1:0] cfg_o,
	output pit_cnt_pkg::pit_ch_lim_s [`PIT_NUM_CH-1:0] lim_o
);

	logic valid;
	logic wr;
	logic rd_start;
	logic rd_ack_q;
	logic [1:0] ch;
	logic ch_ok;
	pit_reg_pkg::pit_reg_e reg_idx;
	pit_reg_pkg::pit_word_u wr_word;
	pit_reg_pkg::pit_word_u rd_word;
	pit_reg_pkg::pit_ctrl_byte_s [`PIT_NUM_CH-1:0] ctrl_q;
	logic [`PIT_NUM_CH-1:0][`PIT_DATA_W-1:0] max_q;
	logic [`PIT_NUM_CH-1:0][`PIT_DATA_W-1:0] ont_q;

	// ============================================================
	// bus decode and acknowledge
	// ============================================================
	assign valid = req_i.cs & req_i.cyc & req_i.stb;
	assign wr = valid & req_i.we;
	// first cycle of a read, the one that samples dat_o
	assign rd_start = valid & ~req_i.we & ~rd_ack_q;
	assign ch = req_i.adr[5:4];
	assign ch_ok = ch < 2'(`PIT_NUM_CH);
	assign reg_idx = pit_reg_pkg::pit_reg_e'(req_i.adr[3:2]);
	assign wr_word.raw = req_i.dat;

	// read ack follows one cycle after the sample
	always_ff @(posedge clk_i) begin
		if (rst_i)
			rd_ack_q <= 1'b0;
		else
			rd_ack_q <= rd_start;
	end

	// writes ack at once, reads once the word is in dat_o
	assign ack_o = valid & (req_i.we | rd_ack_q);

	// ============================================================
	// register storage
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			max_q <= '0;
			ont_q <= '0;
			for (int i = 0; i < `PIT_NUM_CH; i++) begin
				ctrl_q[i] <= '0;
				// channels come out of reset in auto-reload mode
				ctrl_q[i].auto_rld <= 1'b1;
			end
		end else begin
			for (int i = 0; i < `PIT_NUM_CH; i++) begin
				// load is a pulse, drop it unless rewritten below
				ctrl_q[i].load <= 1'b0;
				// one-shot reached terminal count
				if (stop_i[i])
					ctrl_q[i].en <= 1'b0;
				if (wr && ch == 2'(i)) begin
					if (reg_idx == pit_reg_pkg::MAXCNT)
						max_q[i] <= wr_word.raw;
					if (reg_idx == pit_reg_pkg::ONTIME)
						ont_q[i] <= wr_word.raw;
				end
				// control lanes are shared, any channel address reaches them
				// a write in the same cycle as stop wins
				if (wr && reg_idx == pit_reg_pkg::CTRL && req_i.sel[i])
					ctrl_q[i] <= wr_word.lanes[i];
			end
		end
	end

	// ============================================================
	// read path
	// ============================================================
	always_comb begin
		rd_word.raw = '0;
		case (reg_idx)
			pit_reg_pkg::COUNT:
				if (ch_ok)
					rd_word.raw = count_i[ch];
			pit_reg_pkg::MAXCNT:
				if (ch_ok)
					rd_word.raw = max_q[ch];
			pit_reg_pkg::ONTIME:
				if (ch_ok)
					rd_word.raw = ont_q[ch];
			default: begin
				for (int i = 0; i < `PIT_NUM_CH; i++) begin
					rd_word.lanes[i] = ctrl_q[i];
					// load and pad always read back as zero
					rd_word.lanes[i].load = 1'b0;
					rd_word.lanes[i].pad = 1'b0;
				end
			end
		endcase
	end

	// read data holds until the next read
	always_ff @(posedge clk_i) begin
		if (rd_start)
			dat_o <= rd_word.raw;
	end

	// ============================================================
	// channel outputs
	// ============================================================
	always_comb begin
		for (int i = 0; i < `PIT_NUM_CH; i++) begin
			cfg_o[i].en = ctrl_q[i].en;
			cfg_o[i].auto_rld = ctrl_q[i].auto_rld;
			cfg_o[i].ext_clk = ctrl_q[i].ext_clk;
			cfg_o[i].gate_en = ctrl_q[i].gate_en;
			cfg_o[i].bcd = ctrl_q[i].bcd;
			cfg_o[i].up = ctrl_q[i].up;
			cfg_o[i].load = ctrl_q[i].load;
			lim_o[i].maxcnt = max_q[i];
			lim_o[i].ontime = ont_q[i];
		end
	end

endmodule

/* verilog/pit_top.sv */
`timescale 1ns/1ps
`include "pit_defines.svh"

module pit_top (
	input  logic clk_i,
	input  logic rst_i,
	input  logic cs_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [`PIT_DATA_W/8-1:0] sel_i,
	input  logic [`PIT_ADR_W-1:0] adr_i,
	input  logic [`PIT_DATA_W-1:0] dat_i,
	output logic ack_o,
	output logic [`PIT_DATA_W-1:0] dat_o,
	input  logic [`PIT_NUM_CH-1:0] ext_clk_i,
	input  logic [`PIT_NUM_CH-1:0] gate_i,
	output logic [`PIT_NUM_CH-1:0] out_o
);

	pit_reg_pkg::pit_bus_req_s bus_req;
	pit_cnt_pkg::pit_ch_cfg_s [`PIT_NUM_CH-1:0] ch_cfg;
	pit_cnt_pkg::pit_ch_lim_s [`PIT_NUM_CH-1:0] ch_lim;
	logic [`PIT_NUM_CH-1:0][`PIT_DATA_W-1:0] ch_count;
	logic [`PIT_NUM_CH-1:0] ch_stop;

	// bus pins into one request word
	assign bus_req = '{cs: cs_i, cyc: cyc_i, stb: stb_i, we: we_i,
		sel: sel_i, adr: adr_i, dat: dat_i};

	pit_regs i_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(bus_req),
		.ack_o(ack_o),
		.dat_o(dat_o),
		.count_i(ch_count),
		.stop_i(ch_stop),
		.cfg_o(ch_cfg),
		.lim_o(ch_lim)
	);

	// one channel per pin
	for (genvar g = 0; g < `PIT_NUM_CH; g++) begin : g_ch
		pit_channel i_ch (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.cfg_i(ch_cfg[g]),
			.lim_i(ch_lim[g]),
			.ext_clk_i(ext_clk_i[g]),
			.gate_i(gate_i[g]),
			.count_o(ch_count[g]),
			.stop_o(ch_stop[g]),
			.out_o(out_o[g])
		);
	end

endmodule

/* tb/pit_properties.sv */
`timescale 1ns/1ps
`include "pit_defines.svh"

module pit_properties (
	input logic clk_i,
	input logic rst_i,
	input logic cs_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic ack_o,
	input logic [`PIT_NUM_CH-1:0] out_o,
	input logic [`PIT_NUM_CH-1:0] stop_i,
	input pit_cnt_pkg::pit_ch_cfg_s [`PIT_NUM_CH-1:0] cfg_i
);

	// ============================================================
	// bus
	// ============================================================
	a_ack_valid: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> (cs_i && cyc_i && stb_i))
		else $error("ack without a valid request");

	// read data comes one cycle after a held read request
	a_rd_ack_late: assert property (@(posedge clk_i) disable iff (rst_i)
		(ack_o && !we_i) |-> $past(cs_i && cyc_i && stb_i && !we_i))
		else $error("read ack without a request in the cycle before");

	// ============================================================
	// channels
	// ============================================================
	a_out_reset: assert property (@(posedge clk_i)
		rst_i |=> (out_o == '0))
		else $error("output pins not low after reset");

	for (genvar g = 0; g < `PIT_NUM_CH; g++) begin : g_stop
		// only a one-shot channel stops and its enable drops at the next edge
		// unless a write in the stop cycle rewrites the control lane
		a_stop_oneshot: assert property (@(posedge clk_i) disable iff (rst_i)
			stop_i[g] |=> (!$past(cfg_i[g].auto_rld)
				&& (!cfg_i[g].en || $past(cs_i && cyc_i && stb_i && we_i))))
			else $error("stop pulse with auto-reload set or enable left on");
	end

endmodule

bind pit_top pit_properties i_props (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.cs_i(cs_i),
	.cyc_i(cyc_i),
	.stb_i(stb_i),
	.we_i(we_i),
	.ack_o(ack_o),
	.out_o(out_o),
	.stop_i(ch_stop),
	.cfg_i(ch_cfg)
);

/* tb/pit_tb.sv */
`timescale 1ns/1ps
`include "pit_defines.svh"

module pit_tb;

	localparam int RUN_DOWN = 150;
	localparam int RUN_EXT = 150;
	localparam int RUN_SYNC = 120;
	// a run cycle costs up to three clocks when it reads
	localparam int LIMIT = 10 + 300 + 60 + 3 * (RUN_DOWN + RUN_EXT + RUN_SYNC + 120) + 500;

	logic clk_i, rst_i, cs_i, cyc_i, stb_i, we_i, ack_o;
	logic [3:0] sel_i;
	logic [`PIT_ADR_W-1:0] adr_i;
	logic [31:0] dat_i, dat_o, rd_data, val;
	logic [2:0] ext_clk_i, gate_i, out_o;
	logic [31:0] lfsr_state;
	int cycle_cnt;

	// model state with one entry per channel
	logic [2:0] m_en, m_ar, m_ext, m_gen, m_bcd, m_up, m_load, m_out;
	logic [1:0] m_eq [3];
	logic [31:0] m_max [3];
	logic [31:0] m_ont [3];
	logic [31:0] m_cnt [3];

	pit_top i_pit_top (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(cs_i), .cyc_i(cyc_i), .stb_i(stb_i),
		.we_i(we_i), .sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i), .ack_o(ack_o),
		.dat_o(dat_o), .ext_clk_i(ext_clk_i), .gate_i(gate_i), .out_o(out_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// ============================================================
	// helpers
	// ============================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// galois form with taps 32 22 2 1
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// one bcd or binary step over all eight digits
	function automatic logic [31:0] digit_step(input logic [31:0] v, input logic up,
		input logic bcd);
		logic [3:0] dig, top;
		logic carry;
		top = bcd ? 4'd9 : 4'hf;
		carry = 1'b1;
		for (int d = 0; d < 8; d++) begin
			dig = v[4*d +: 4];
			if (carry) begin
				if (up) begin
					carry = (dig == top);
					v[4*d +: 4] = carry ? 4'd0 : dig + 4'd1;
				end else begin
					carry = (dig == 4'd0);
					v[4*d +: 4] = carry ? top : dig - 4'd1;
				end
			end
		end
		return v;
	endfunction

	function automatic logic [31:0] ctrl_word();
		logic [31:0] w;
		w = '0;
		// load and pad always read as zero
		for (int i = 0; i < 3; i++)
			w[8*i +: 8] = {1'b0, m_up[i], m_bcd[i], m_gen[i], m_ext[i], m_ar[i], m_en[i], 1'b0};
		return w;
	endfunction

	function automatic logic [5:0] reg_adr(input logic [1:0] ch, input pit_reg_pkg::pit_reg_e r);
		return {ch, r, 2'b00};
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	// ============================================================
	// cycle model
	// ============================================================
	always @(posedge clk_i) begin : model
		logic rise, cen, tc, wr;
		logic [7:0] lane;
		if (rst_i) begin
			{m_en, m_ext, m_gen, m_bcd, m_up, m_load, m_out} <= '0;
			m_ar <= 3'b111;
			for (int i = 0; i < 3; i++) begin
				m_eq[i] <= 2'b00;
				m_max[i] <= '0;
				m_ont[i] <= '0;
				m_cnt[i] <= '0;
			end
		end else begin
			wr = cs_i & cyc_i & stb_i & we_i;
			for (int i = 0; i < 3; i++) begin
				rise = m_eq[i][0] & ~m_eq[i][1];
				cen = m_en[i] & (m_ext[i] ? rise : 1'b1) & (m_gen[i] ? gate_i[i] : 1'b1);
				tc = m_up[i] ? (m_cnt[i] == m_max[i]) : (m_cnt[i] == '0);
				m_eq[i] <= {m_eq[i][0], ext_clk_i[i]};
				m_load[i] <= 1'b0;
				if (m_load[i]) begin
					m_cnt[i] <= m_up[i] ? '0 : m_max[i];
				end else if (cen) begin
					// terminal count wins over the on-time match
					if (tc)
						m_out[i] <= m_up[i];
					else if (m_cnt[i] == m_ont[i])
						m_out[i] <= ~m_up[i];
					if (tc && m_ar[i])
						m_cnt[i] <= m_up[i] ? '0 : m_max[i];
					else
						m_cnt[i] <= digit_step(m_cnt[i], m_up[i], m_bcd[i]);
					if (tc && !m_ar[i])
						m_en[i] <= 1'b0;
				end
				// a control write lands after the stop clear
				lane = dat_i[8*i +: 8];
				if (wr && adr_i[3:2] == pit_reg_pkg::CTRL && sel_i[i])
					{m_up[i], m_bcd[i], m_gen[i], m_ext[i], m_ar[i], m_en[i],
						m_load[i]} <= lane[6:0];
				if (wr && adr_i[5:4] == 2'(i) && adr_i[3:2] == pit_reg_pkg::MAXCNT)
					m_max[i] <= dat_i;
				if (wr && adr_i[5:4] == 2'(i) && adr_i[3:2] == pit_reg_pkg::ONTIME)
					m_ont[i] <= dat_i;
			end
		end
	end

	// pins compared every cycle
	always @(negedge clk_i) begin
		if (!rst_i)
			check_val("out_o", {29'd0, m_out}, {29'd0, out_o});
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT)
			fail_run("timeout, the run did not finish in time");
	end

	// ============================================================
	// bus tasks
	// ============================================================
	task automatic bus_write(input logic [5:0] adr, input logic [3:0] sel, input logic [31:0] d);
		@(negedge clk_i);
		{cs_i, cyc_i, stb_i, we_i} = 4'b1111;
		adr_i = adr;
		sel_i = sel;
		dat_i = d;
		#1 check_val("write ack", 1, ack_o);
		@(negedge clk_i);
		{cs_i, cyc_i, stb_i, we_i} = 4'b0000;
	endtask

	task automatic bus_read(input logic [5:0] adr, input string name, output logic [31:0] d);
		logic [31:0] exp;
		int n;
		@(negedge clk_i);
		{cs_i, cyc_i, stb_i, we_i} = 4'b1110;
		adr_i = adr;
		sel_i = 4'hf;
		// value the register holds at the sampling edge
		case (adr[3:2])
			pit_reg_pkg::COUNT: exp = m_cnt[adr[5:4]];
			pit_reg_pkg::MAXCNT: exp = m_max[adr[5:4]];
			pit_reg_pkg::ONTIME: exp = m_ont[adr[5:4]];
			default: exp = ctrl_word();
		endcase
		#1 check_val("read ack early", 0, ack_o);
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!ack_o && n < 8);
		if (!ack_o)
			fail_run("read was never acknowledged");
		check_val("read ack latency", 1, n);
		check_val(name, exp, dat_o);
		d = dat_o;
		@(negedge clk_i);
		{cs_i, cyc_i, stb_i, we_i} = 4'b0000;
	endtask

	// idle or read the count with fresh pin patterns on idle cycles
	task automatic run_cycles(input int n, input logic [1:0] ch);
		for (int k = 0; k < n; k++) begin
			if (rand_bits(3) == 0) begin
				bus_read(reg_adr(ch, pit_reg_pkg::COUNT), "count", rd_data);
			end else begin
				@(negedge clk_i);
				ext_clk_i = 3'(rand_bits(3));
				gate_i = 3'(rand_bits(3) | rand_bits(3));
			end
		end
	endtask

	// ============================================================
	// tests
	// ============================================================
	initial begin
		lfsr_state = 32'h5beb;
		cycle_cnt = 0;
		rst_i = 1'b1;
		{cs_i, cyc_i, stb_i, we_i} = 4'b0000;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		ext_clk_i = '0;
		gate_i = '0;
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		// register readback
		for (int c = 0; c < 3; c++) begin
			bus_write(reg_adr(2'(c), pit_reg_pkg::MAXCNT), 4'hf, rand_bits(32));
			bus_write(reg_adr(2'(c), pit_reg_pkg::ONTIME), 4'hf, rand_bits(32));
			bus_read(reg_adr(2'(c), pit_reg_pkg::MAXCNT), "maxcnt readback", rd_data);
			bus_read(reg_adr(2'(c), pit_reg_pkg::ONTIME), "ontime readback", rd_data);
		end
		bus_write(reg_adr(0, pit_reg_pkg::CTRL), 4'hf, rand_bits(32));
		bus_read(reg_adr(0, pit_reg_pkg::CTRL), "ctrl readback", rd_data);

		// no ack while the chip select is low
		@(negedge clk_i);
		{cs_i, cyc_i, stb_i, we_i} = {3'b011, rand_bits(1) == 1};
		repeat (4) begin
			#1 check_val("ack without cs", 0, ack_o);
			@(negedge clk_i);
		end
		{cs_i, cyc_i, stb_i, we_i} = 4'b0000;

		// binary down count with reload on channel 0
		bus_write(reg_adr(0, pit_reg_pkg::MAXCNT), 4'hf, 32'd8 + rand_bits(4));
		bus_write(reg_adr(0, pit_reg_pkg::ONTIME), 4'hf, rand_bits(3));
		bus_write(reg_adr(0, pit_reg_pkg::CTRL), 4'b0001, 32'h07);
		run_cycles(RUN_DOWN, 0);

		// bcd up count in one shot on channel 1
		bus_write(reg_adr(1, pit_reg_pkg::MAXCNT), 4'hf,
			{24'd0, 4'(rand_bits(2) + 1), 4'(rand_bits(3))});
		bus_write(reg_adr(1, pit_reg_pkg::ONTIME), 4'hf, 32'h05);
		bus_write(reg_adr(1, pit_reg_pkg::CTRL), 4'b0010, 32'h6300);
		while (m_en[1] || m_load[1]) begin
			bus_read(reg_adr(1, pit_reg_pkg::COUNT), "bcd count", val);
			for (int d = 0; d < 8; d++)
				if (val[4*d +: 4] > 4'd9)
					fail_run("bcd count holds a digit above 9");
			run_cycles(2, 1);
		end
		bus_read(reg_adr(1, pit_reg_pkg::CTRL), "ctrl after stop", rd_data);
		check_val("enable after stop", 0, {31'd0, rd_data[9]});

		// external clock and gate on channel 2
		bus_write(reg_adr(2, pit_reg_pkg::MAXCNT), 4'hf, 32'd10 + rand_bits(4));
		bus_write(reg_adr(2, pit_reg_pkg::ONTIME), 4'hf, rand_bits(3));
		bus_write(reg_adr(2, pit_reg_pkg::CTRL), 4'b0100, 32'h1f_0000);
		run_cycles(RUN_EXT, 2);

		// one write starts all three channels
		for (int c = 0; c < 3; c++) begin
			bus_write(reg_adr(2'(c), pit_reg_pkg::MAXCNT), 4'hf, 32'd6 + rand_bits(4));
			bus_write(reg_adr(2'(c), pit_reg_pkg::ONTIME), 4'hf, rand_bits(3));
		end
		bus_write(reg_adr(0, pit_reg_pkg::CTRL), 4'b0111, 32'h07_0707);
		run_cycles(RUN_SYNC, 2'(rand_bits(1)));

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* compile.f */
+incdir+verilog
verilog/pit_reg_pkg.sv
verilog/pit_cnt_pkg.sv
verilog/pit_digit_counter.sv
verilog/pit_channel.sv
verilog/pit_regs.sv
verilog/pit_top.sv
tb/pit_properties.sv
tb/pit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := pit_tb
FLIST     := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

SRCS := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
